/* logic/timer_pkg.sv */
package timer_pkg;

    ////////////////////////////////////////////////////
    // time fields, plain binary
    ////////////////////////////////////////////////////

    typedef logic [6:0] hours_t;
    typedef logic [6:0] minutes_t;
    typedef logic [6:0] seconds_t;
    typedef logic [6:0] hundredths_t;

    // field moduli
    localparam hours_t      HOURS_PER_DAY         = 7'd24;
    localparam minutes_t    MINUTES_PER_HOUR      = 7'd60;
    localparam seconds_t    SECONDS_PER_MINUTE    = 7'd60;
    localparam hundredths_t HUNDREDTHS_PER_SECOND = 7'd100;

    ////////////////////////////////////////////////////
    // setting control
    ////////////////////////////////////////////////////

    // same encoding as the para_select switches
    typedef enum logic [1:0] {
        FIELD_NONE    = 2'b00,
        FIELD_SECONDS = 2'b01,
        FIELD_MINUTES = 2'b10,
        FIELD_HOURS   = 2'b11
    } setting_field_e;

    typedef enum logic [1:0] {
        SET_IDLE = 2'd0,   // free running
        SET_EDIT = 2'd1,   // counter stopped, field follows entry
        SET_HOLD = 2'd2    // value taken, wait for switches back at 00
    } set_state_e;

endpackage

/* logic/display_pkg.sv */
package display_pkg;

    ////////////////////////////////////////////////////
    // display types
    ////////////////////////////////////////////////////

    typedef logic [3:0] digit_t;

    // active low, a..g in bits 0..6, point in bit 7
    typedef logic [7:0] segments_t;

    // bit 7 is position 0 (leftmost)
    typedef logic [7:0] digit_mask_t;

    typedef logic [2:0] scan_index_t;

    ////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////

    localparam digit_t DIGIT_BLANK = 4'd15;

    // points after hours, minutes, seconds and at the far right
    localparam digit_mask_t POINT_MASK = 8'b0101_0101;

endpackage

/* logic/time_bus_if.sv */
`timescale 1ns/100ps

// one time value, hours down to hundredths
interface time_bus_if;

    timer_pkg::hours_t      hours;
    timer_pkg::minutes_t    minutes;
    timer_pkg::seconds_t    seconds;
    timer_pkg::hundredths_t hundredths;

    modport source (
        output hours, minutes, seconds, hundredths
    );

    modport sink (
        input hours, minutes, seconds, hundredths
    );

endinterface

/* logic/time_counter.sv */
`timescale 1ns/100ps

module time_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      tick,
    input  logic                      run,
    input  logic                      clear,
    input  timer_pkg::setting_field_e load_field,
    input  timer_pkg::hours_t         load_value,
    time_bus_if.source                out
);

    timer_pkg::hours_t      hours;
    timer_pkg::minutes_t    minutes;
    timer_pkg::seconds_t    seconds;
    timer_pkg::hundredths_t hundredths;

    logic step;
    logic hund_wrap;
    logic sec_wrap;
    logic min_wrap;
    logic hour_wrap;

    assign step      = tick && run;
    assign hund_wrap = hundredths == timer_pkg::HUNDREDTHS_PER_SECOND - 7'd1;
    assign sec_wrap  = seconds == timer_pkg::SECONDS_PER_MINUTE - 7'd1;
    assign min_wrap  = minutes == timer_pkg::MINUTES_PER_HOUR - 7'd1;
    assign hour_wrap = hours == timer_pkg::HOURS_PER_DAY - 7'd1;

    // clear and load win over counting
    always_ff @(posedge clk) begin
        if (!reset || clear) begin
            hours      <= '0;
            minutes    <= '0;
            seconds    <= '0;
            hundredths <= '0;
        end else if (load_field != timer_pkg::FIELD_NONE) begin
            case (load_field)
                timer_pkg::FIELD_SECONDS: seconds <= load_value % timer_pkg::SECONDS_PER_MINUTE;
                timer_pkg::FIELD_MINUTES: minutes <= load_value % timer_pkg::MINUTES_PER_HOUR;
                timer_pkg::FIELD_HOURS:   hours   <= load_value % timer_pkg::HOURS_PER_DAY;
                default: ;
            endcase
        end else if (step) begin
            hundredths <= hund_wrap ? '0 : hundredths + 7'd1;
            if (hund_wrap) begin
                seconds <= sec_wrap ? '0 : seconds + 7'd1;
                if (sec_wrap) begin
                    minutes <= min_wrap ? '0 : minutes + 7'd1;
                    if (min_wrap) begin
                        hours <= hour_wrap ? '0 : hours + 7'd1;   // midnight
                    end
                end
            end
        end
    end

    assign out.hours      = hours;
    assign out.minutes    = minutes;
    assign out.seconds    = seconds;
    assign out.hundredths = hundredths;

    field_range: assert property (@(posedge clk) disable iff (!reset)
        hours < timer_pkg::HOURS_PER_DAY
        && minutes < timer_pkg::MINUTES_PER_HOUR
        && seconds < timer_pkg::SECONDS_PER_MINUTE
        && hundredths < timer_pkg::HUNDREDTHS_PER_SECOND);

endmodule

/* logic/clock_keeper.sv */
`timescale 1ns/100ps

module clock_keeper (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      tick,
    input  logic                      edit_enable,
    input  logic                      read_para,
    input  timer_pkg::setting_field_e para_select,
    input  timer_pkg::hours_t         entry_value,
    output display_pkg::digit_mask_t  blink_mask,
    output logic                      chime,
    time_bus_if.source                now
);

    timer_pkg::set_state_e     state;
    timer_pkg::set_state_e     state_next;
    timer_pkg::setting_field_e load_field;
    logic                      editing;

    assign editing    = state == timer_pkg::SET_EDIT;
    assign load_field = editing ? para_select : timer_pkg::FIELD_NONE;

    //////////////////////////////////////////////////
    // setting FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= timer_pkg::SET_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            timer_pkg::SET_IDLE: begin
                if (edit_enable && para_select != timer_pkg::FIELD_NONE) begin
                    state_next = timer_pkg::SET_EDIT;
                end
            end
            timer_pkg::SET_EDIT: begin
                if (read_para) begin
                    state_next = timer_pkg::SET_HOLD;
                end else if (!edit_enable) begin
                    state_next = timer_pkg::SET_IDLE;   // left clock mode mid-edit
                end
            end
            timer_pkg::SET_HOLD: begin
                if (para_select == timer_pkg::FIELD_NONE) begin
                    state_next = timer_pkg::SET_IDLE;
                end
            end
            default: state_next = timer_pkg::SET_IDLE;
        endcase
    end

    // blink the field being edited
    always_comb begin
        blink_mask = '0;
        if (editing) begin
            case (para_select)
                timer_pkg::FIELD_HOURS:   blink_mask = 8'b1100_0000;
                timer_pkg::FIELD_MINUTES: blink_mask = 8'b0011_0000;
                timer_pkg::FIELD_SECONDS: blink_mask = 8'b0000_1100;
                default:                  blink_mask = 8'b1111_1111;
            endcase
        end
    end

    // beeps on even seconds at the top of the hour
    always_ff @(posedge clk) begin
        if (!reset) begin
            chime <= 1'b0;
        end else begin
            chime <= now.minutes == '0 && now.seconds < 7'd10 && !now.seconds[0];
        end
    end

    time_counter u_counter (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .run        (!editing),
        .clear      (1'b0),
        .load_field (load_field),
        .load_value (entry_value),
        .out        (now)
    );

    read_to_hold: assert property (@(posedge clk) disable iff (!reset)
        (state == timer_pkg::SET_EDIT && read_para) |=> state == timer_pkg::SET_HOLD);

endmodule

/* logic/stopwatch.sv */
`timescale 1ns/100ps

module stopwatch (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       enable,
    input  logic       start_stop,
    input  logic       clear,
    time_bus_if.source now
);

    logic start_q;
    logic clear_q;
    logic running;
    logic start_rise;
    logic clear_rise;

    // button edges
    assign start_rise = start_stop && !start_q;
    assign clear_rise = clear && !clear_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            start_q <= 1'b0;
            clear_q <= 1'b0;
            running <= 1'b0;   // paused
        end else begin
            start_q <= start_stop;
            clear_q <= clear;
            if (enable && start_rise) begin
                running <= !running;
            end
        end
    end

    // keeps counting in the background
    time_counter u_counter (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .run        (running),
        .clear      (clear_rise),
        .load_field (timer_pkg::FIELD_NONE),
        .load_value ('0),
        .out        (now)
    );

endmodule

/* logic/display_driver.sv */
`timescale 1ns/100ps

module display_driver #(
    parameter int SCAN_TICKS  = 10_000,
    parameter int BLINK_TICKS = 50_000_000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     time_format,
    input  display_pkg::digit_mask_t blink_mask,
    time_bus_if.sink                 shown,
    output logic                     afternoon,
    output display_pkg::segments_t   segs,
    output display_pkg::digit_mask_t an
);

    localparam int SCAN_W  = $clog2(SCAN_TICKS + 1);
    localparam int BLINK_W = $clog2(BLINK_TICKS + 1);

    logic [SCAN_W-1:0]         scan_count;
    logic [BLINK_W-1:0]        blink_count;
    logic                      blink_phase;
    display_pkg::scan_index_t  scan_index;
    display_pkg::scan_index_t  mask_bit;
    timer_pkg::hours_t         hours_shown;
    display_pkg::digit_t       digits [8];
    display_pkg::digit_t       digit_sel;

    function automatic display_pkg::digit_t tens(input logic [6:0] value);
        return display_pkg::digit_t'(value / 7'd10);
    endfunction

    function automatic display_pkg::digit_t units(input logic [6:0] value);
        return display_pkg::digit_t'(value % 7'd10);
    endfunction

    function automatic logic [6:0] decode(input display_pkg::digit_t digit);
        case (digit)
            4'd0:    return 7'b100_0000;
            4'd1:    return 7'b111_1001;
            4'd2:    return 7'b010_0100;
            4'd3:    return 7'b011_0000;
            4'd4:    return 7'b001_1001;
            4'd5:    return 7'b001_0010;
            4'd6:    return 7'b000_0010;
            4'd7:    return 7'b111_1000;
            4'd8:    return 7'b000_0000;
            4'd9:    return 7'b001_0000;
            default: return 7'b111_1111;   // blank, also 10..14
        endcase
    endfunction

    //////////////////////////////////////////////////
    // scan and blink timing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            scan_count <= '0;
            scan_index <= '0;
        end else if (scan_count == SCAN_W'(SCAN_TICKS - 1)) begin
            scan_count <= '0;
            scan_index <= scan_index + 3'd1;
        end else begin
            scan_count <= scan_count + SCAN_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            blink_count <= '0;
            blink_phase <= 1'b0;
        end else if (blink_count == BLINK_W'(BLINK_TICKS - 1)) begin
            blink_count <= '0;
            blink_phase <= !blink_phase;   // high = blanked half
        end else begin
            blink_count <= blink_count + BLINK_W'(1);
        end
    end

    //////////////////////////////////////////////////
    // digits
    //////////////////////////////////////////////////

    assign afternoon   = time_format && shown.hours > 7'd12;
    assign hours_shown = afternoon ? shown.hours - 7'd12 : shown.hours;

    always_comb begin
        digits[0] = tens(hours_shown);
        digits[1] = units(hours_shown);
        digits[2] = tens(shown.minutes);
        digits[3] = units(shown.minutes);
        digits[4] = tens(shown.seconds);
        digits[5] = units(shown.seconds);
        digits[6] = tens(shown.hundredths);
        digits[7] = units(shown.hundredths);
    end

    assign mask_bit  = ~scan_index;   // position p sits at bit 7 - p
    assign digit_sel = (blink_mask[mask_bit] && blink_phase) ? display_pkg::DIGIT_BLANK
                                                              : digits[scan_index];

    assign segs = {~display_pkg::POINT_MASK[mask_bit], decode(digit_sel)};
    assign an   = ~(8'b1000_0000 >> scan_index);

    an_one_low: assert property (@(posedge clk) disable iff (!reset) $onehot(~an));

endmodule

/* logic/digital_timer.sv */
`timescale 1ns/100ps

module digital_timer #(
    parameter int TICKS_PER_HUNDREDTH = 1_000_000,
    parameter int SCAN_TICKS          = 10_000,
    parameter int BLINK_TICKS         = 50_000_000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_stop,
    input  logic       clear,
    input  logic       read_para,
    input  logic       time_format,
    input  logic       mode,          // 0 clock, 1 stopwatch
    input  logic [1:0] para_select,
    input  logic [3:0] data_h,
    input  logic [3:0] data_l,
    output logic       afternoon,
    output logic       chime,
    output logic [7:0] segs,
    output logic [7:0] an
);

    localparam int PRESCALE_W = $clog2(TICKS_PER_HUNDREDTH + 1);

    logic [PRESCALE_W-1:0]    prescale_count;
    logic                     hundredth_tick;
    logic [3:0]               digit_h;
    logic [3:0]               digit_l;
    timer_pkg::hours_t        entry_value;
    display_pkg::digit_mask_t clock_mask;
    display_pkg::digit_mask_t shown_mask;

    time_bus_if clock_time ();
    time_bus_if watch_time ();
    time_bus_if shown_time ();

    //////////////////////////////////////////////////
    // hundredth prescaler
    //////////////////////////////////////////////////

    assign hundredth_tick = prescale_count == PRESCALE_W'(TICKS_PER_HUNDREDTH - 1);

    always_ff @(posedge clk) begin
        if (!reset || hundredth_tick) begin
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + PRESCALE_W'(1);
        end
    end

    // bcd entry, digits above 9 read as 9
    assign digit_h     = (data_h > 4'd9) ? 4'd9 : data_h;
    assign digit_l     = (data_l > 4'd9) ? 4'd9 : data_l;
    assign entry_value = 7'd10 * {3'b000, digit_h} + {3'b000, digit_l};

    clock_keeper u_clock (
        .clk         (clk),
        .reset       (reset),
        .tick        (hundredth_tick),
        .edit_enable (!mode),
        .read_para   (read_para),
        .para_select (timer_pkg::setting_field_e'(para_select)),
        .entry_value (entry_value),
        .blink_mask  (clock_mask),
        .chime       (chime),
        .now         (clock_time)
    );

    stopwatch u_watch (
        .clk        (clk),
        .reset      (reset),
        .tick       (hundredth_tick),
        .enable     (mode),
        .start_stop (start_stop),
        .clear      (clear),
        .now        (watch_time)
    );

    // mode select
    assign shown_time.hours      = mode ? watch_time.hours      : clock_time.hours;
    assign shown_time.minutes    = mode ? watch_time.minutes    : clock_time.minutes;
    assign shown_time.seconds    = mode ? watch_time.seconds    : clock_time.seconds;
    assign shown_time.hundredths = mode ? watch_time.hundredths : clock_time.hundredths;
    assign shown_mask            = mode ? '0 : clock_mask;   // stopwatch never blinks

    display_driver #(
        .SCAN_TICKS  (SCAN_TICKS),
        .BLINK_TICKS (BLINK_TICKS)
    ) u_display (
        .clk         (clk),
        .reset       (reset),
        .time_format (time_format),
        .blink_mask  (shown_mask),
        .shown       (shown_time),
        .afternoon   (afternoon),
        .segs        (segs),
        .an          (an)
    );

endmodule

/* testbench/tb_digital_timer.sv */
`timescale 1ns/100ps

module tb_digital_timer;

    localparam int TICKS     = 4;
    localparam int SCAN      = 2;
    localparam int BLINK     = 64;
    localparam int MAX_LINES = 64;
    localparam string DATA_PATH = "testbench/testdata_digital_timer.txt";

    logic       clk;
    logic       reset;
    logic       start_stop;
    logic       clear;
    logic       read_para;
    logic       time_format;
    logic       mode;
    logic [1:0] para_select;
    logic [3:0] data_h;
    logic [3:0] data_l;
    logic       afternoon;
    logic       chime;
    logic [7:0] segs;
    logic [7:0] an;

    int   stim [MAX_LINES][15];   // one row per data line
    int   line_count  = 0;
    int   budget      = 0;
    int   cycle_count = 0;
    logic loaded      = 1'b0;
    int   cap  [4];               // hours, minutes, seconds, hundredths
    int   prev [4];
    int   cap_af;
    int   cap_chime;

    digital_timer #(
        .TICKS_PER_HUNDREDTH (TICKS),
        .SCAN_TICKS          (SCAN),
        .BLINK_TICKS         (BLINK)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .start_stop  (start_stop),
        .clear       (clear),
        .read_para   (read_para),
        .time_format (time_format),
        .mode        (mode),
        .para_select (para_select),
        .data_h      (data_h),
        .data_l      (data_l),
        .afternoon   (afternoon),
        .chime       (chime),
        .segs        (segs),
        .an          (an)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    ////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////

    task automatic value_error(input string name, input int got, input int expected);
        $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, expected);
        $display("Finished with errors");
        $fatal(1, "wrong value");
    endtask

    task automatic problem(input string what);
        $display("[ERROR] %0t %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "check failed");
    endtask

    // active low a..g back to a digit, 15 for blank
    function automatic int seg_to_digit(input logic [6:0] s);
        case (s)
            7'b100_0000: return 0;
            7'b111_1001: return 1;
            7'b010_0100: return 2;
            7'b011_0000: return 3;
            7'b001_1001: return 4;
            7'b001_0010: return 5;
            7'b000_0010: return 6;
            7'b111_1000: return 7;
            7'b000_0000: return 8;
            7'b001_0000: return 9;
            7'b111_1111: return 15;
            default:     return -1;
        endcase
    endfunction

    // all four fields equal to the capture before
    function automatic logic capture_unchanged();
        for (int f = 0; f < 4; f++) begin
            if (cap[f] != prev[f]) return 1'b0;
        end
        return 1'b1;
    endfunction

    ////////////////////////////////////////////////////
    // display sampling
    ////////////////////////////////////////////////////

    task automatic sample_position(output int pos, output int digit);
        int expected_point;
        @(negedge clk);
        pos = 0;
        assert ($onehot(~an)) else problem("an does not have exactly one low bit");
        for (int i = 0; i < 8; i++) begin
            if (!an[7-i]) pos = i;   // bit 7 is the leftmost position
        end
        digit = seg_to_digit(segs[6:0]);
        assert (digit >= 0) else problem("segs show no known digit pattern");
        expected_point = (pos % 2 == 1) ? 0 : 1;   // point at odd positions
        assert (int'(segs[7]) == expected_point)
            else value_error("segs[7]", int'(segs[7]), expected_point);
    endtask

    task automatic capture();
        int         digits [8];
        logic [7:0] seen;
        int         pos;
        int         d;
        int         n;
        seen = '0;
        n    = 0;
        prev = cap;
        while (seen != 8'hff) begin
            sample_position(pos, d);
            digits[pos] = d;
            seen[pos]   = 1'b1;
            n++;
            assert (n <= 16 * SCAN + 4) else problem("scan did not visit all eight positions");
        end
        for (int f = 0; f < 4; f++) begin
            cap[f] = digits[2*f] * 10 + digits[2*f+1];
        end
        cap_af    = int'(afternoon);
        cap_chime = int'(chime);
    endtask

    // hours at positions 0-1, minutes 2-3, seconds 4-5
    task automatic check_blink(input int field);
        int   pos;
        int   d;
        logic in_field;
        logic blanked;
        blanked = 1'b0;
        repeat (2 * BLINK + 8 * SCAN) begin
            sample_position(pos, d);
            in_field = field == 0 || pos / 2 == 3 - field;
            if (d == 15) begin
                assert (in_field) else problem("a position outside the edited field blanked");
                blanked = 1'b1;
            end
        end
        assert (blanked) else problem("edited field never blanked within a blink period");
    endtask

    task automatic compare_time(input int i, input logic zero_hundredths);
        assert (cap[0] == stim[i][10]) else value_error("hours", cap[0], stim[i][10]);
        assert (cap[1] == stim[i][11]) else value_error("minutes", cap[1], stim[i][11]);
        assert (cap[2] == stim[i][12]) else value_error("seconds", cap[2], stim[i][12]);
        if (zero_hundredths) begin
            assert (cap[3] == 0) else value_error("hundredths", cap[3], 0);
        end
        if (stim[i][13] != 2) begin   // 2 = don't care
            assert (cap_af == stim[i][13]) else value_error("afternoon", cap_af, stim[i][13]);
        end
        if (stim[i][14] != 2) begin
            assert (cap_chime == stim[i][14]) else value_error("chime", cap_chime, stim[i][14]);
        end
    endtask

    ////////////////////////////////////////////////////
    // one data line
    ////////////////////////////////////////////////////

    task automatic run_line(input int i);
        int   start;
        logic matched;
        @(posedge clk);
        #1;
        mode        = 1'(stim[i][0]);
        para_select = 2'(stim[i][1]);
        data_h      = 4'(stim[i][2]);
        data_l      = 4'(stim[i][3]);
        read_para   = 1'(stim[i][4]);
        time_format = 1'(stim[i][5]);
        start_stop  = 1'(stim[i][6]);
        clear       = 1'(stim[i][7]);
        if (stim[i][9] == 6) begin
            // wait column counts hundredths here
            start   = cycle_count;
            matched = 1'b0;
            while (!matched) begin
                capture();
                matched = cap[0] == stim[i][10] && cap[1] == stim[i][11]
                          && cap[2] == stim[i][12];
                assert (matched || cycle_count - start <= stim[i][8] * TICKS + 16 * SCAN)
                    else problem("clock did not roll over in time");
            end
            compare_time(i, 1'b0);
        end else begin
            repeat (stim[i][8]) @(posedge clk);
            case (stim[i][9])
                0: begin
                    capture();
                    compare_time(i, 1'b0);
                end
                1: check_blink(stim[i][1]);
                2: begin
                    capture();
                    assert (!capture_unchanged())
                        else problem("stopwatch display did not advance");
                end
                3: begin
                    capture();
                    assert (capture_unchanged())
                        else problem("stopwatch display changed while paused");
                end
                5: capture();
                7: begin
                    capture();
                    compare_time(i, 1'b1);
                end
                default: ;
            endcase
        end
    endtask

    initial begin
        int    fd;
        int    k;
        string line;
        mode        = 1'b0;
        para_select = 2'b00;
        data_h      = 4'd0;
        data_l      = 4'd0;
        read_para   = 1'b0;
        time_format = 1'b0;
        start_stop  = 1'b0;
        clear       = 1'b0;
        reset       = 1'b0;
        cap         = '{0, 0, 0, 0};
        fd = $fopen(DATA_PATH, "r");
        assert (fd != 0) else problem("cannot open the test data file");
        while (!$feof(fd)) begin
            k = $fgets(line, fd);
            if (k > 1 && line[0] != "#") begin
                k = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    stim[line_count][0], stim[line_count][1], stim[line_count][2],
                    stim[line_count][3], stim[line_count][4], stim[line_count][5],
                    stim[line_count][6], stim[line_count][7], stim[line_count][8],
                    stim[line_count][9], stim[line_count][10], stim[line_count][11],
                    stim[line_count][12], stim[line_count][13], stim[line_count][14]);
                assert (k == 15) else problem("malformed line in the test data file");
                line_count++;
            end
        end
        $fclose(fd);
        budget = 200;
        for (int i = 0; i < line_count; i++) begin
            budget += (stim[i][9] == 6 ? stim[i][8] * TICKS : stim[i][8])
                      + 2 * BLINK + 40 * SCAN + 4;
        end
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        #1 reset = 1'b1;

        for (int i = 0; i < line_count; i++) begin
            run_line(i);
        end
        $display("Finished with no errors");
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        #(budget * 10);
        $display("[ERROR] %0t watchdog expired before the tests finished", $time);
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

/* testbench/testdata_digital_timer.txt */
# mode para data_h data_l read_para time_format start_stop clear wait check hh mm ss af chime
# check 0 time, 1 blink, 2 advancing, 3 frozen, 4 none, 5 capture, 6 rollover, 7 zero
0 0 0 0 0 0 0 0 10 0 0 0 0 0 1
0 3 3 7 0 0 0 0 10 1 0 0 0 2 2
0 3 3 7 1 0 0 0 2 0 13 0 0 0 1
0 0 0 0 0 1 0 0 4 0 1 0 0 1 1
0 0 0 0 0 0 0 0 2 0 13 0 0 0 1
0 2 9 9 0 0 0 0 10 1 0 0 0 2 2
0 2 9 9 1 0 0 0 2 0 13 39 0 0 0
0 0 0 0 0 0 0 0 4 4 0 0 0 0 0
0 3 0 0 0 0 0 0 4 4 0 0 0 0 0
0 2 5 9 0 0 0 0 4 4 0 0 0 0 0
0 1 5 9 0 0 0 0 4 4 0 0 0 0 0
0 1 5 9 1 0 0 0 2 0 0 59 59 0 0
0 0 0 0 0 0 0 0 100 6 1 0 0 0 1
1 0 0 0 0 0 0 0 4 7 0 0 0 0 2
1 0 0 0 0 0 1 0 2 4 0 0 0 0 0
1 0 0 0 0 0 0 0 40 2 0 0 0 0 2
1 0 0 0 0 0 1 0 2 4 0 0 0 0 0
1 0 0 0 0 0 0 0 4 5 0 0 0 0 0
1 0 0 0 0 0 0 0 40 3 0 0 0 0 0
1 0 0 0 0 0 0 1 2 4 0 0 0 0 0
1 0 0 0 0 0 0 0 4 7 0 0 0 0 2

/* tb.f */
logic/timer_pkg.sv
logic/display_pkg.sv
logic/time_bus_if.sv
logic/time_counter.sv
logic/clock_keeper.sv
logic/stopwatch.sv
logic/display_driver.sv
logic/digital_timer.sv
testbench/tb_digital_timer.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_digital_timer -f tb.f

sim:
	verilator --binary --timing --assert --top-module tb_digital_timer -f tb.f -o sim
	-obj_dir/sim > sim.log 2>&1
	cat sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
